//--- filelist.f
verilog/cci_pkg.sv
verilog/cci_can_issue.sv
verilog/cci_read_arbiter.sv
verilog/frame_line_reader.sv
verilog/status_mgr.sv
verilog/afu_read_top.sv
test/afu_read_asserts.sv
test/afu_read_tb.sv

//--- Makefile
# Verilator build, run, lint and clean for the AFU read path
VERILATOR := verilator
TOP       := afu_read_tb
FILELIST  := filelist.f
FLAGS     := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall --timing
OBJ_DIR   := obj_dir
LOG       := sim.log
RUN_ARGS  := +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, whatever the simulator's own exit status
run: build
	-./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- test/afu_read_tb.sv
// Testbench for the AFU read path; runs two frames and two status polls under random almost-full
`timescale 1ns/1ps

module afu_read_tb import cci_pkg::*; ();

   localparam int FRAME_LINES = 12;
   // Two frames of lines plus the two status reads
   localparam int TOTAL_READS = 2 * FRAME_LINES + 2;
   localparam int TIMEOUT_CYCLES = 40 * TOTAL_READS + 200;

   logic           clk;
   logic           resetb;
   logic           lp_initdone;
   t_csr_afu_state csr;
   logic           reader_start;
   logic           writer_start;
   logic           status_poll;
   t_tx_c0         tx0;
   logic           tx0_almostfull;
   logic           reader_done;
   logic           writer_done;
   logic [15:0]    read_count;

   logic [31:0] rng_state;
   logic        af_active;
   int unsigned cycle_count;
   int unsigned errors;
   int unsigned assert_fails;
   int unsigned rd_cycles;
   int unsigned status_reads;
   // Index 0 is the frame reader, index 1 the frame writer
   int unsigned line_cnt [2];
   int unsigned next_idx [2];
   int unsigned done_cnt [2];

   afu_read_top #(
      .MAX_LINES_W (14),
      .COUNT_W     (16)
   ) dut_i (
      .clk            (clk),
      .resetb         (resetb),
      .lp_initdone    (lp_initdone),
      .csr            (csr),
      .reader_start   (reader_start),
      .writer_start   (writer_start),
      .status_poll    (status_poll),
      .tx0            (tx0),
      .tx0_almostfull (tx0_almostfull),
      .reader_done    (reader_done),
      .writer_done    (writer_done),
      .read_count     (read_count)
   );

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // One frame line seen on the channel, checked against the expected order and address
   task automatic check_frame_read(input int src, input logic [31:0] base);
      int unsigned idx;
      idx = tx0.header.mdata[13:0];
      if (idx != next_idx[src]) begin
         errors++;
         $display("error %0t: tx0.header.mdata index got %0d expected %0d",
                  $time, idx, next_idx[src]);
      end
      if (tx0.header.addr !== base + 32'(next_idx[src])) begin
         errors++;
         $display("error %0t: tx0.header.addr got %h expected %h",
                  $time, tx0.header.addr, base + 32'(next_idx[src]));
      end
      if (tx0.header.req_type !== req_rdline) begin
         errors++;
         $display("error %0t: tx0.header.req_type got %b expected %b",
                  $time, tx0.header.req_type, req_rdline);
      end
      if (line_cnt[src] >= FRAME_LINES) begin
         errors++;
         $display("source %0d read more lines than the frame holds", src);
      end
      next_idx[src]++;
      line_cnt[src]++;
   endtask

   task automatic check_status_read();
      status_reads++;
      if (tx0.header.addr !== csr.status_addr) begin
         errors++;
         $display("error %0t: tx0.header.addr got %h expected %h",
                  $time, tx0.header.addr, csr.status_addr);
      end
      if (tx0.header.mdata[13:0] !== 14'd0) begin
         errors++;
         $display("error %0t: tx0.header.mdata index got %0d expected 0",
                  $time, tx0.header.mdata[13:0]);
      end
      // Status has lowest priority so it trails both frames
      if (done_cnt[0] == 0 || done_cnt[1] == 0) begin
         errors++;
         $display("status read went out before both frames had finished");
      end
   endtask

   task automatic check_frame_totals(input int src);
      if (line_cnt[src] != FRAME_LINES) begin
         errors++;
         $display("error %0t: line count of source %0d got %0d expected %0d",
                  $time, src, line_cnt[src], FRAME_LINES);
      end
      if (done_cnt[src] != 1) begin
         errors++;
         $display("error %0t: done count of source %0d got %0d expected 1",
                  $time, src, done_cnt[src]);
      end
   endtask

   always #10 clk = ~clk;

   // Outputs are registered, so the falling edge sees them settled
   always @(negedge clk) begin
      if (tx0.rdvalid === 1'b1) begin
         rd_cycles++;
         case (tx0.header.mdata[15:14])
            src_reader: check_frame_read(0, csr.reader_base);
            src_writer: check_frame_read(1, csr.writer_base);
            src_status: check_status_read();
            default: begin
               errors++;
               $display("read on the channel carries an unknown source tag");
            end
         endcase
      end
      // The last line of a frame shows up together with its done pulse
      if (reader_done === 1'b1) begin
         done_cnt[0]++;
         if (line_cnt[0] != FRAME_LINES) begin
            errors++;
            $display("error %0t: reader_done with line count %0d expected %0d",
                     $time, line_cnt[0], FRAME_LINES);
         end
      end
      if (writer_done === 1'b1) begin
         done_cnt[1]++;
         if (line_cnt[1] != FRAME_LINES) begin
            errors++;
            $display("error %0t: writer_done with line count %0d expected %0d",
                     $time, line_cnt[1], FRAME_LINES);
         end
      end
   end

   // Random back-pressure, roughly one cycle in four
   always @(negedge clk) begin
      tx0_almostfull = af_active && (rng_state[1:0] == 2'd0);
      rng_state = xorshift(rng_state);
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TESTS FAILED");
         $finish;
      end
   end

   initial begin
      clk = 1'b0;
      resetb = 1'b0;
      lp_initdone = 1'b0;
      csr = '0;
      csr.afu_en = 1'b1;
      csr.reader_base = 32'h0001_0000;
      csr.writer_base = 32'h0002_0400;
      csr.status_addr = 32'h0000_3f00;
      csr.frame_lines = MDATA_IDX_W'(FRAME_LINES);
      reader_start = 1'b0;
      writer_start = 1'b0;
      status_poll = 1'b0;
      tx0_almostfull = 1'b0;
      rng_state = 32'hbefc6cb4;
      af_active = 1'b0;
      cycle_count = 0;
      errors = 0;
      rd_cycles = 0;
      status_reads = 0;
      line_cnt = '{0, 0};
      next_idx = '{0, 0};
      done_cnt = '{0, 0};

      repeat (2) @(negedge clk);
      resetb = 1'b1;
      af_active = 1'b1;

      // Frames start before the link is up, so their first requests have to wait
      reader_start = 1'b1;
      writer_start = 1'b1;
      @(negedge clk);
      reader_start = 1'b0;
      writer_start = 1'b0;
      repeat (6) @(negedge clk);
      lp_initdone = 1'b1;
      repeat (4) @(negedge clk);

      // Software disable in the middle of both frames, with a poll left pending
      csr.afu_en = 1'b0;
      repeat (4) @(negedge clk);
      status_poll = 1'b1;
      @(negedge clk);
      status_poll = 1'b0;
      repeat (12) @(negedge clk);
      csr.afu_en = 1'b1;

      while (done_cnt[0] == 0 || done_cnt[1] == 0) begin
         @(negedge clk);
      end
      // The pending poll drains once both frames are through
      while (status_reads < 1) begin
         @(negedge clk);
      end
      repeat (6) @(negedge clk);

      // A poll on an idle channel gives exactly one status read
      status_poll = 1'b1;
      @(negedge clk);
      status_poll = 1'b0;
      while (status_reads < 2) begin
         @(negedge clk);
      end
      repeat (10) @(negedge clk);

      check_frame_totals(0);
      check_frame_totals(1);
      if (status_reads != 2) begin
         errors++;
         $display("error %0t: status read count got %0d expected 2", $time, status_reads);
      end
      if (read_count !== 16'(rd_cycles)) begin
         errors++;
         $display("error %0t: read_count got %0d expected %0d", $time, read_count, rd_cycles);
      end

      assert_fails = dut_i.asserts_i.fail_count;
      $display("errors: scoreboard %0d, assertions %0d", errors, assert_fails);
      if (errors == 0 && assert_fails == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- test/afu_read_asserts.sv
// Concurrent checks on TX channel 0 of the AFU read path; bound into afu_read_top
`timescale 1ns/1ps

module afu_read_asserts import cci_pkg::*; (
   input logic           clk,
   input logic           resetb,
   input logic           lp_initdone,
   input t_csr_afu_state csr,
   input t_tx_c0         tx0,
   input logic           tx0_almostfull,
   input logic           reader_done,
   input logic           writer_done,
   input t_frame_arb     frame_reader,
   input t_frame_arb     frame_writer
);

   // Failed assertion count
   int unsigned fail_count = 0;

   logic [MDATA_IDX_W-1:0] last_idx;
   logic                   rd_reader;
   logic                   rd_status;

   assign last_idx = csr.frame_lines - 1'b1;
   assign rd_reader = tx0.rdvalid && (tx0.header.mdata[15:14] == src_reader);
   assign rd_status = tx0.rdvalid && (tx0.header.mdata[15:14] == src_status);

   // The first cycle out of reset is quiet on the channel
   reset_quiet: assert property (@(posedge clk) resetb && !$past(resetb) |-> !tx0.rdvalid)
      else begin
         fail_count++;
         $error("error %0t: tx0.rdvalid is 1, expected 0 right after reset", $time);
      end

   // A read needs the link up two cycles back and software enable in the grant cycle
   issue_gated: assert property (@(posedge clk) disable iff (!resetb)
      tx0.rdvalid |-> $past(lp_initdone, 2) && $past(csr.afu_en))
      else begin
         fail_count++;
         $error("read left on the channel while issue was not allowed at %0t", $time);
      end

   // Almost-full blocks in the grant cycle itself
   almostfull_kept: assert property (@(posedge clk) disable iff (!resetb)
      tx0.rdvalid |-> !$past(tx0_almostfull))
      else begin
         fail_count++;
         $error("read left on the channel after an almost-full cycle at %0t", $time);
      end

   reader_done_last: assert property (@(posedge clk) disable iff (!resetb)
      reader_done |-> tx0.rdvalid && tx0.header.mdata == {src_reader, last_idx})
      else begin
         fail_count++;
         $error("error %0t: tx0.header.mdata got %h expected %h with reader_done",
                $time, tx0.header.mdata, {src_reader, last_idx});
      end

   writer_done_last: assert property (@(posedge clk) disable iff (!resetb)
      writer_done |-> tx0.rdvalid && tx0.header.mdata == {src_writer, last_idx})
      else begin
         fail_count++;
         $error("error %0t: tx0.header.mdata got %h expected %h with writer_done",
                $time, tx0.header.mdata, {src_writer, last_idx});
      end

   // Two reader reads in a row only when the writer was idle in the second grant cycle
   reader_alternates: assert property (@(posedge clk) disable iff (!resetb)
      rd_reader && $past(rd_reader) |-> !$past(frame_writer.read.request))
      else begin
         fail_count++;
         $error("frame reader won twice in a row against a waiting writer at %0t", $time);
      end

   status_lowest: assert property (@(posedge clk) disable iff (!resetb)
      rd_status |-> !$past(frame_reader.read.request) && !$past(frame_writer.read.request))
      else begin
         fail_count++;
         $error("status read went ahead of a waiting frame request at %0t", $time);
      end

endmodule

bind afu_read_top afu_read_asserts asserts_i (
   .clk            (clk),
   .resetb         (resetb),
   .lp_initdone    (lp_initdone),
   .csr            (csr),
   .tx0            (tx0),
   .tx0_almostfull (tx0_almostfull),
   .reader_done    (reader_done),
   .writer_done    (writer_done),
   .frame_reader   (frame_reader),
   .frame_writer   (frame_writer)
);

//--- verilog/afu_read_top.sv
// Top of the AFU read-request path; connects the requesters, arbiter and issue control
`timescale 1ns/1ps

module afu_read_top import cci_pkg::*; #(
   parameter int MAX_LINES_W = 14,
   parameter int COUNT_W     = 16
) (
   input  logic               clk,
   input  logic               resetb,
   input  logic               lp_initdone,
   input  t_csr_afu_state     csr,
   input  logic               reader_start,
   input  logic               writer_start,
   input  logic               status_poll,
   output t_tx_c0             tx0,
   input  logic               tx0_almostfull,
   output logic               reader_done,
   output logic               writer_done,
   output logic [COUNT_W-1:0] read_count
);

   t_frame_arb         frame_reader;
   t_frame_arb         frame_writer;
   t_frame_arb         status_mgr_req;
   t_channel_grant_arb read_grant;

   // Frame reader, tagged as the reader source
   frame_line_reader #(
      .SRC_TAG     (src_reader),
      .MAX_LINES_W (MAX_LINES_W)
   ) frame_reader_i (
      .clk    (clk),
      .resetb (resetb),
      .start  (reader_start),
      .base   (csr.reader_base),
      .lines  (csr.frame_lines[MAX_LINES_W-1:0]),
      .grant  (read_grant.reader_grant),
      .req    (frame_reader),
      .done   (reader_done)
   );

   // Frame writer fetches its lines through the same read channel
   frame_line_reader #(
      .SRC_TAG     (src_writer),
      .MAX_LINES_W (MAX_LINES_W)
   ) frame_writer_i (
      .clk    (clk),
      .resetb (resetb),
      .start  (writer_start),
      .base   (csr.writer_base),
      .lines  (csr.frame_lines[MAX_LINES_W-1:0]),
      .grant  (read_grant.writer_grant),
      .req    (frame_writer),
      .done   (writer_done)
   );

   status_mgr #(
      .SRC_TAG (src_status)
   ) status_mgr_i (
      .clk         (clk),
      .resetb      (resetb),
      .poll        (status_poll),
      .status_addr (csr.status_addr),
      .grant       (read_grant.status_grant),
      .req         (status_mgr_req)
   );

   cci_read_arbiter #(
      .COUNT_W (COUNT_W)
   ) read_arb_i (
      .clk            (clk),
      .resetb         (resetb),
      .lp_initdone    (lp_initdone),
      .csr            (csr),
      .status_mgr_req (status_mgr_req),
      .frame_writer   (frame_writer),
      .frame_reader   (frame_reader),
      .read_grant     (read_grant),
      .tx0            (tx0),
      .tx0_almostfull (tx0_almostfull),
      .read_count     (read_count)
   );

endmodule

//--- verilog/status_mgr.sv
// Status-line read requester raising one read per poll; instantiated once by the AFU read top
`timescale 1ns/1ps

module status_mgr import cci_pkg::*; #(
   parameter logic [1:0] SRC_TAG = src_status
) (
   input  logic        clk,
   input  logic        resetb,
   input  logic        poll,
   input  logic [31:0] status_addr,
   input  logic        grant,
   output t_frame_arb  req
);

   logic        pending;
   logic [31:0] addr_q;

   // A poll while a read is still waiting is ignored
   always_ff @(posedge clk) begin
      if (!resetb) begin
         pending <= 1'b0;
      end else if (!pending && poll) begin
         pending <= 1'b1;
      end else if (grant) begin
         pending <= 1'b0;
      end
   end

   // Address sampled with the poll so it cannot move under a waiting request
   always_ff @(posedge clk) begin
      if (!pending && poll) begin
         addr_q <= status_addr;
      end
   end

   // Status is always a single line at index zero
   always_comb begin
      req.read.request = pending;
      req.read_header.req_type = req_rdline;
      req.read_header.addr = addr_q;
      req.read_header.mdata = {SRC_TAG, MDATA_IDX_W'(0)};
   end

endmodule

//--- verilog/frame_line_reader.sv
// Line-sequential frame read requester; instantiated as frame reader and frame writer
`timescale 1ns/1ps

module frame_line_reader import cci_pkg::*; #(
   parameter logic [1:0] SRC_TAG     = src_reader,
   parameter int         MAX_LINES_W = 14
) (
   input  logic                   clk,
   input  logic                   resetb,
   input  logic                   start,
   input  logic [31:0]            base,
   input  logic [MAX_LINES_W-1:0] lines,
   input  logic                   grant,
   output t_frame_arb             req,
   output logic                   done
);

   logic                   busy;
   logic [31:0]            base_q;
   logic [MAX_LINES_W-1:0] lines_q;
   logic [MAX_LINES_W-1:0] line_idx;
   logic                   last_line;

   // The line count is at least one, so lines_q - 1 is the final index
   assign last_line = (line_idx == lines_q - MAX_LINES_W'(1));

   // Control state
   // A start while a frame is in flight is dropped
   always_ff @(posedge clk) begin
      if (!resetb) begin
         busy <= 1'b0;
         line_idx <= '0;
         done <= 1'b0;
      end else begin
         done <= 1'b0;
         if (!busy) begin
            if (start) begin
               busy <= 1'b1;
               line_idx <= '0;
            end
         end else if (grant) begin
            if (last_line) begin
               busy <= 1'b0;
               done <= 1'b1;
            end else begin
               line_idx <= line_idx + 1'b1;
            end
         end
      end
   end

   // Frame geometry is captured once per start
   always_ff @(posedge clk) begin
      if (!busy && start) begin
         base_q <= base;
         lines_q <= lines;
      end
   end

   // The request holds with a stable header until granted
   always_comb begin
      req.read.request = busy;
      req.read_header.req_type = req_rdline;
      req.read_header.addr = base_q + 32'(line_idx);
      req.read_header.mdata = {SRC_TAG, MDATA_IDX_W'(line_idx)};
   end

endmodule

//--- verilog/cci_read_arbiter.sv
// Three-way read arbiter driving TX channel 0; instantiated once by the AFU read top
`timescale 1ns/1ps

module cci_read_arbiter import cci_pkg::*; #(
   parameter int COUNT_W = 16
) (
   input  logic               clk,
   input  logic               resetb,
   input  logic               lp_initdone,
   input  t_csr_afu_state     csr,
   input  t_frame_arb         status_mgr_req,
   input  t_frame_arb         frame_writer,
   input  t_frame_arb         frame_reader,
   output t_channel_grant_arb read_grant,
   output t_tx_c0             tx0,
   input  logic               tx0_almostfull,
   output logic [COUNT_W-1:0] read_count
);

   // Favor state used to alternate between the two frame requesters
   typedef enum logic {
      FAVOR_READER,
      FAVOR_WRITER
   } t_favor;

   t_favor     favor;
   logic       fsm_can_issue;
   logic       can_issue;
   logic       any_grant;
   t_tx_header header;

   // Software enable is folded in here, the FSM handles link state and almost-full
   assign can_issue = fsm_can_issue && csr.afu_en;

   // Any grant is one read accepted onto the channel
   assign any_grant = read_grant.reader_grant | read_grant.writer_grant |
                      read_grant.status_grant;

   cci_can_issue #(
      .COUNT_W (COUNT_W)
   ) issue_ctl_i (
      .clk         (clk),
      .resetb      (resetb),
      .lp_initdone (lp_initdone),
      .almostfull  (tx0_almostfull),
      .issue       (any_grant),
      .can_issue   (fsm_can_issue),
      .read_count  (read_count)
   );

   // After a reader grant the writer gets the next turn
   always_ff @(posedge clk) begin
      if (!resetb) begin
         favor <= FAVOR_READER;
      end else begin
         favor <= read_grant.reader_grant ? FAVOR_WRITER : FAVOR_READER;
      end
   end

   // Priority select and header mux
   // The reader header is the default so the mux has no zero leg
   always_comb begin
      read_grant = '0;
      header = frame_reader.read_header;
      if (frame_reader.read.request &&
          (favor == FAVOR_READER || !frame_writer.read.request)) begin
         read_grant.reader_grant = can_issue;
      end else if (frame_writer.read.request) begin
         header = frame_writer.read_header;
         read_grant.writer_grant = can_issue;
      end else if (status_mgr_req.read.request) begin
         // Status only goes when neither frame requester wants the channel
         header = status_mgr_req.read_header;
         read_grant.status_grant = can_issue;
      end
   end

   // One cycle from grant to the channel
   always_ff @(posedge clk) begin
      tx0.header <= header;
      if (!resetb) begin
         tx0.rdvalid <= 1'b0;
      end else begin
         tx0.rdvalid <= any_grant;
      end
   end

endmodule

//--- verilog/cci_can_issue.sv
// Issue-control FSM for TX channel 0; instantiated inside the read arbiter
`timescale 1ns/1ps

module cci_can_issue #(
   parameter int COUNT_W = 16
) (
   input  logic               clk,
   input  logic               resetb,
   input  logic               lp_initdone,
   input  logic               almostfull,
   input  logic               issue,
   output logic               can_issue,
   output logic [COUNT_W-1:0] read_count
);

   // Nothing may leave until the link has finished initializing
   typedef enum logic {
      ST_WAIT_INIT,
      ST_RUN
   } t_issue_state;

   t_issue_state state;

   // Once the link is up we stay in the run state until reset
   always_ff @(posedge clk) begin
      if (!resetb) begin
         state <= ST_WAIT_INIT;
      end else if (state == ST_WAIT_INIT && lp_initdone) begin
         state <= ST_RUN;
      end
   end

   // Almost-full blocks issue in the same cycle it is seen
   // The arbiter adds the software enable on top of this
   assign can_issue = (state == ST_RUN) && !almostfull;

   // Count of reads accepted by the arbiter, wraps at 2**COUNT_W
   // Each issue pulse becomes exactly one rdvalid one cycle later
   always_ff @(posedge clk) begin
      if (!resetb) begin
         read_count <= '0;
      end else if (issue) begin
         read_count <= read_count + 1'b1;
      end
   end

endmodule

//--- verilog/cci_pkg.sv
// Shared types and constants for the AFU read-request path; imported by every RTL module
package cci_pkg;

   // Width of the line index carried in the low bits of mdata
   localparam int MDATA_IDX_W = 14;

   // Source tags carried in the top two bits of mdata
   localparam logic [1:0] src_reader = 2'd0;
   localparam logic [1:0] src_writer = 2'd1;
   localparam logic [1:0] src_status = 2'd2;

   // Request type code for a cache-line read on TX channel 0
   localparam logic [1:0] req_rdline = 2'b01;

   // One read request as it leaves on the channel
   typedef struct packed {
      logic [1:0]  req_type;
      logic [31:0] addr;
      // Source tag in the top two bits, line index below it
      logic [15:0] mdata;
   } t_tx_header;

   // Request level of one requester, held until the grant
   typedef struct packed {
      logic request;
   } t_read_req;

   // What a requester offers the arbiter each cycle
   typedef struct packed {
      t_read_req  read;
      t_tx_header read_header;
   } t_frame_arb;

   // Single-cycle grant pulses back to the requesters
   typedef struct packed {
      logic reader_grant;
      logic writer_grant;
      logic status_grant;
   } t_channel_grant_arb;

   // Registered TX channel 0 word
   typedef struct packed {
      t_tx_header header;
      logic       rdvalid;
   } t_tx_c0;

   // CSR state, already decoded by software-facing logic
   typedef struct packed {
      logic                   afu_en;
      logic [31:0]            reader_base;
      logic [31:0]            writer_base;
      logic [31:0]            status_addr;
      logic [MDATA_IDX_W-1:0] frame_lines;
   } t_csr_afu_state;

endpackage
